// ==== src/stq_pkg.sv ====
package stq_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 64;

  // 32 banks of 4 bytes
  localparam int bank_w = 5;

  // aligned store data spans three banks
  localparam int lane_w = 96;

  localparam int stq_depth = 8;
  localparam int stq_idx_w = $clog2(stq_depth);

  // queue pointers carry a wrap bit
  localparam int ptr_w = stq_idx_w + 1;

  typedef enum logic [1:0] {
    sz_byte  = 2'd0,
    sz_half  = 2'd1,
    sz_word  = 2'd2,
    sz_dword = 2'd3
  } size_e;

  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    size_e             size;
  } st_addr_t;

  typedef struct packed {
    logic                 en;
    logic [stq_idx_w-1:0] idx;
    logic [data_w-1:0]    data;
  } st_data_t;

  // one store leaving the queue
  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    size_e             size;
    logic [data_w-1:0] data;
  } drain_t;

  typedef struct packed {
    logic bus_holds;
    logic miss_holds;
    logic miss_pause;
    logic insert_data;
  } cache_hold_t;

  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    logic [bank_w-1:0] bank_bgn;
    logic [bank_w-1:0] bank_end;
    logic [3:0]        bgn_ben;
    logic [3:0]        end_ben;
    logic [lane_w-1:0] data;
  } st_req_t;

endpackage

// ==== src/ben_calc.sv ====
`timescale 1ns/1ps

module ben_calc import stq_pkg::*; (
  input  logic [addr_w-1:0] addr,
  input  size_e             size,
  output logic [bank_w-1:0] bank_bgn,
  output logic [bank_w-1:0] bank_end,
  output logic [3:0]        bgn_ben,
  output logic [3:0]        end_ben
);

  logic [1:0] offset;
  logic [3:0] len;
  logic [3:0] stop;
  logic [3:0] last;
  logic [3:0] tail_ben;

  assign offset = addr[1:0];
  assign len    = 4'd1 << size;

  // first byte past the access, and the last byte, from bank start
  assign stop = {2'b00, offset} + len;
  assign last = stop - 4'd1;

  assign bank_bgn = addr[bank_w+1:2];

  // wraps around the 32 banks
  assign bank_end = bank_bgn + bank_w'(last[3:2]);

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      bgn_ben[b]  = (b >= offset) && (b < stop);
      tail_ben[b] = (b <= last[1:0]);
    end
  end

  // single bank access keeps the begin mask
  assign end_ben = (last[3:2] != 2'b00) ? tail_ben : bgn_ben;

endmodule

// ==== src/wdata_align.sv ====
`timescale 1ns/1ps

module wdata_align import stq_pkg::*; (
  input  logic [data_w-1:0] data,
  input  size_e             size,
  input  logic [1:0]        low,
  output logic [lane_w-1:0] lane_data
);

  logic [3:0]        len;
  logic [data_w-1:0] kept;

  assign len = 4'd1 << size;

  // zero bytes past the store length
  always_comb begin
    for (int b = 0; b < data_w / 8; b++) begin
      kept[b*8 +: 8] = (b < len) ? data[b*8 +: 8] : 8'h00;
    end
  end

  // byte 0 of the store lands on lane low
  assign lane_data = lane_w'(kept) << {low, 3'b000};

endmodule

// ==== src/wreq_stage.sv ====
`timescale 1ns/1ps

module wreq_stage import stq_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  drain_t      drain,
  input  cache_hold_t hold,
  output logic        drain_ready,
  output st_req_t     st_req
);

  logic              en_q;
  logic [addr_w-1:0] addr_q;
  size_e             size_q;
  logic [data_w-1:0] data_q;
  logic              accept;
  logic [bank_w-1:0] bank_bgn;
  logic [bank_w-1:0] bank_end;
  logic [3:0]        bgn_ben;
  logic [3:0]        end_ben;
  logic [lane_w-1:0] lane_data;

  // any cache hold blocks the stage
  assign drain_ready = !(hold.bus_holds || hold.miss_holds ||
                         hold.miss_pause || hold.insert_data);
  assign accept = drain.en && drain_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q <= 1'b0;
    end else begin
      en_q <= accept;
    end
  end

  // payload stays put while held
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= drain.addr;
      size_q <= drain.size;
      data_q <= drain.data;
    end
  end

  ben_calc i_ben_calc (
    .addr     (addr_q),
    .size     (size_q),
    .bank_bgn (bank_bgn),
    .bank_end (bank_end),
    .bgn_ben  (bgn_ben),
    .end_ben  (end_ben)
  );

  wdata_align i_wdata_align (
    .data      (data_q),
    .size      (size_q),
    .low       (addr_q[1:0]),
    .lane_data (lane_data)
  );

  assign st_req = '{
    en:       en_q,
    addr:     addr_q,
    bank_bgn: bank_bgn,
    bank_end: bank_end,
    bgn_ben:  bgn_ben,
    end_ben:  end_ben,
    data:     lane_data
  };

endmodule

// ==== src/store_queue.sv ====
`timescale 1ns/1ps

module store_queue import stq_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  st_addr_t             st_addr,
  input  st_data_t             st_data,
  input  logic                 commit,
  input  logic                 except,
  input  logic                 drain_ready,
  output drain_t               drain,
  output logic [stq_idx_w-1:0] alloc_idx,
  output logic                 stq_full
);

  // head <= cmt <= tail, in queue order
  logic [ptr_w-1:0]     head_q;
  logic [ptr_w-1:0]     cmt_q;
  logic [ptr_w-1:0]     tail_q;
  logic [ptr_w-1:0]     cmt_nxt;
  logic [ptr_w-1:0]     used;
  logic [ptr_w-1:0]     uncmt;
  logic [stq_idx_w-1:0] head_idx;
  logic [stq_depth-1:0] dvalid_q;
  logic [stq_depth-1:0] discard;
  logic                 drain_en;
  logic                 do_commit;
  logic                 do_alloc;
  logic                 do_pop;

  logic [addr_w-1:0] addr_mem [stq_depth];
  size_e             size_mem [stq_depth];
  logic [data_w-1:0] data_mem [stq_depth];

  assign used      = tail_q - head_q;
  assign stq_full  = (used == ptr_w'(stq_depth));
  assign alloc_idx = tail_q[stq_idx_w-1:0];
  assign head_idx  = head_q[stq_idx_w-1:0];

  // commit only moves over allocated entries
  assign do_commit = commit && (cmt_q != tail_q);
  assign cmt_nxt   = do_commit ? cmt_q + 1'b1 : cmt_q;
  assign uncmt     = tail_q - cmt_nxt;

  // a flush in the same cycle drops the new entry as well
  assign do_alloc = st_addr.en && !except && !stq_full;

  // head must be committed and hold its data
  assign drain_en = (head_q != cmt_q) && dvalid_q[head_idx];
  assign do_pop   = drain_en && drain_ready;

  assign drain = '{
    en:   drain_en,
    addr: addr_mem[head_idx],
    size: size_mem[head_idx],
    data: data_mem[head_idx]
  };

  // slots between the new commit pointer and the tail
  always_comb begin
    for (int i = 0; i < stq_depth; i++) begin
      discard[i] = except &&
        ({1'b0, stq_idx_w'(i) - cmt_nxt[stq_idx_w-1:0]} < uncmt);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q   <= '0;
      cmt_q    <= '0;
      tail_q   <= '0;
      dvalid_q <= '0;
    end else begin
      if (do_pop) begin
        head_q <= head_q + 1'b1;
      end
      cmt_q <= cmt_nxt;
      if (except) begin
        tail_q <= cmt_nxt;
      end else if (do_alloc) begin
        tail_q <= tail_q + 1'b1;
      end
      for (int i = 0; i < stq_depth; i++) begin
        if (do_pop && head_idx == stq_idx_w'(i)) begin
          dvalid_q[i] <= 1'b0;
        end
        if (st_data.en && st_data.idx == stq_idx_w'(i)) begin
          dvalid_q[i] <= 1'b1;
        end
        // flush wins over a data write to the same slot
        if (discard[i]) begin
          dvalid_q[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_alloc) begin
      addr_mem[alloc_idx] <= st_addr.addr;
      size_mem[alloc_idx] <= st_addr.size;
    end
    if (st_data.en) begin
      data_mem[st_data.idx] <= st_data.data;
    end
  end

endmodule

// ==== src/fun_stq.sv ====
`timescale 1ns/1ps

module fun_stq import stq_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  st_addr_t             st_addr,
  input  st_data_t             st_data,
  input  logic                 commit,
  input  logic                 except,
  input  cache_hold_t          hold,
  output logic                 stq_full,
  output logic [stq_idx_w-1:0] alloc_idx,
  output st_req_t              st_req
);

  drain_t drain;
  logic   drain_ready;

  store_queue i_store_queue (
    .clk         (clk),
    .rst         (rst),
    .st_addr     (st_addr),
    .st_data     (st_data),
    .commit      (commit),
    .except      (except),
    .drain_ready (drain_ready),
    .drain       (drain),
    .alloc_idx   (alloc_idx),
    .stq_full    (stq_full)
  );

  // single write port into the cache
  wreq_stage i_wreq_stage (
    .clk         (clk),
    .rst         (rst),
    .drain       (drain),
    .hold        (hold),
    .drain_ready (drain_ready),
    .st_req      (st_req)
  );

endmodule

// ==== tests/fun_stq_assert.sv ====
`timescale 1ns/1ps

module fun_stq_assert import stq_pkg::*; (
  input logic        clk,
  input logic        rst,
  input st_addr_t    st_addr,
  input cache_hold_t hold,
  input logic        stq_full,
  input st_req_t     st_req
);

  // outputs idle in the cycle after a reset edge
  reset_idle: assert property (@(posedge clk) rst |=> (!st_req.en && !stq_full))
    else $error("st_req.en or stq_full active right after reset");

  // a held stage accepts nothing
  hold_blocks: assert property (@(posedge clk) disable iff (rst)
    (|hold) |=> !st_req.en)
    else $error("st_req.en high one cycle after a cache hold");

  // producer respects the full flag
  no_push_full: assert property (@(posedge clk) disable iff (rst)
    stq_full |-> !st_addr.en)
    else $error("store address pushed while the queue is full");

endmodule

bind fun_stq fun_stq_assert i_fun_stq_assert (.*);

// ==== tests/tb_fun_stq.sv ====
`timescale 1ns/1ps

module tb_fun_stq import stq_pkg::*; ();

  localparam int run_cycles = 2000;
  localparam int max_cycles = 4 * run_cycles;
  localparam int max_seq    = 4096;

  logic                 clk;
  logic                 rst;
  st_addr_t             st_addr;
  st_data_t             st_data;
  logic                 commit;
  logic                 except;
  cache_hold_t          hold;
  logic                 stq_full;
  logic [stq_idx_w-1:0] alloc_idx;
  st_req_t              st_req;

  logic [15:0] lfsr = 16'd18846;
  int          cycle_cnt = 0;

  // model of the queue, one record per allocation
  logic [addr_w-1:0] m_addr [max_seq];
  size_e             m_size [max_seq];
  logic [data_w-1:0] m_data [max_seq];
  int                slot_seq [stq_depth];
  int                exp_q [$];
  int                pending [$];
  int                tail_cnt = 0;
  int                cmt_cnt = 0;
  int                head_cnt = 0;
  int                seq_cnt = 0;

  fun_stq i_fun_stq (
    .clk       (clk),
    .rst       (rst),
    .st_addr   (st_addr),
    .st_data   (st_data),
    .commit    (commit),
    .except    (except),
    .hold      (hold),
    .stq_full  (stq_full),
    .alloc_idx (alloc_idx),
    .st_req    (st_req)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] draw(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], next_bit()};
    end
    return v;
  endfunction

  function automatic int byte_count(input size_e size);
    case (size)
      sz_byte: return 1;
      sz_half: return 2;
      sz_word: return 4;
      default: return 8;
    endcase
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic compare_hex(input string name, input logic [lane_w-1:0] expv,
                             input logic [lane_w-1:0] actv);
    assert (actv === expv) else begin
      fail_run($sformatf("error %s expected %h actual %h", name, expv, actv));
    end
  endtask

  task automatic check_request(input int seq);
    logic [addr_w-1:0] a;
    logic [bank_w-1:0] bgn;
    logic [3:0]        bben;
    logic [3:0]        eben;
    logic [lane_w-1:0] lane;
    int                off;
    int                len;
    int                last;
    int                span;
    a    = m_addr[seq];
    off  = int'(a[1:0]);
    len  = byte_count(m_size[seq]);
    last = off + len - 1;
    span = last / 4;
    bgn  = a[6:2];
    for (int b = 0; b < 4; b++) begin
      bben[b] = (b >= off) && (b < off + len);
      eben[b] = (b <= last % 4);
    end
    if (span == 0) begin
      eben = bben;
    end
    // store bytes land on lanes off .. off+len-1
    lane = '0;
    for (int j = 0; j < len; j++) begin
      lane[(off + j) * 8 +: 8] = m_data[seq][j * 8 +: 8];
    end
    compare_hex("st_req.addr", lane_w'(a), lane_w'(st_req.addr));
    compare_hex("st_req.bank_bgn", lane_w'(bgn), lane_w'(st_req.bank_bgn));
    compare_hex("st_req.bank_end", lane_w'(bank_w'(bgn + bank_w'(span))),
                lane_w'(st_req.bank_end));
    compare_hex("st_req.bgn_ben", lane_w'(bben), lane_w'(st_req.bgn_ben));
    compare_hex("st_req.end_ben", lane_w'(eben), lane_w'(st_req.end_ben));
    compare_hex("st_req.data", lane, st_req.data);
  endtask

  task automatic check_outputs();
    int seq;
    if (st_req.en) begin
      if (exp_q.size() == 0) begin
        fail_run("st_req.en is high but no committed store is waiting");
      end else begin
        seq = exp_q.pop_front();
        check_request(seq);
        head_cnt++;
      end
    end
    compare_hex("alloc_idx", lane_w'(tail_cnt % stq_depth), lane_w'(alloc_idx));
    compare_hex("stq_full", lane_w'(tail_cnt - head_cnt == stq_depth), lane_w'(stq_full));
  endtask

  task automatic drop_pending(input int slot);
    for (int i = 0; i < pending.size(); i++) begin
      if (pending[i] == slot) begin
        pending.delete(i);
        break;
      end
    end
  endtask

  task automatic drive_inputs(input int c, input bit finishing);
    bit                fill;
    bit                do_alloc;
    bit                do_data;
    int                k;
    int                slot;
    logic [data_w-1:0] d;
    st_addr  = '0;
    st_data  = '0;
    commit   = 1'b0;
    except   = 1'b0;
    hold     = '0;
    do_alloc = 1'b0;
    // bursts with no commit fill the queue with uncommitted stores
    fill = !finishing && ((c % 200) < 24);
    if (finishing) begin
      commit  = 1'b1;
      do_data = 1'b1;
    end else begin
      if (draw(3) == 0) begin
        hold = cache_hold_t'(4'(draw(4)));
      end
      if (fill) begin
        do_alloc = 1'b1;
        except   = ((c % 400) == 23);
      end else begin
        commit   = (draw(3) < 3);
        except   = (draw(5) == 0);
        do_alloc = draw(1) != 0;
      end
      do_data = !except && (draw(3) < 5);
    end
    // commit is taken before the flush in the same cycle
    if (commit && cmt_cnt != tail_cnt) begin
      exp_q.push_back(slot_seq[cmt_cnt % stq_depth]);
      cmt_cnt++;
    end
    if (except) begin
      for (int i = cmt_cnt; i < tail_cnt; i++) begin
        drop_pending(i % stq_depth);
      end
      tail_cnt = cmt_cnt;
    end
    // data goes to a random waiting slot, so out of index order
    if (do_data && pending.size() > 0) begin
      k    = int'(draw(4)) % pending.size();
      slot = pending[k];
      pending.delete(k);
      d = draw(64);
      m_data[slot_seq[slot]] = d;
      st_data.en   = 1'b1;
      st_data.idx  = stq_idx_w'(slot);
      st_data.data = d;
    end
    if (do_alloc && !except && !stq_full) begin
      slot = tail_cnt % stq_depth;
      slot_seq[slot]   = seq_cnt;
      m_addr[seq_cnt]  = addr_w'(draw(addr_w));
      m_size[seq_cnt]  = size_e'(2'(draw(2)));
      st_addr.en       = 1'b1;
      st_addr.addr     = m_addr[seq_cnt];
      st_addr.size     = m_size[seq_cnt];
      pending.push_back(slot);
      seq_cnt++;
      tail_cnt++;
    end
  endtask

  initial begin
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt >= max_cycles) begin
        fail_run("timeout, the queue did not drain in time");
      end
    end
  end

  initial begin
    rst     = 1'b1;
    st_addr = '0;
    st_data = '0;
    commit  = 1'b0;
    except  = 1'b0;
    hold    = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    for (int c = 0; c < run_cycles; c++) begin
      @(negedge clk);
      check_outputs();
      drive_inputs(c, 1'b0);
    end
    // no holds or flushes, commit and fill everything left
    while (exp_q.size() > 0 || head_cnt != tail_cnt) begin
      @(negedge clk);
      check_outputs();
      drive_inputs(0, 1'b1);
    end
    @(negedge clk);
    check_outputs();
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== src.f ====
src/stq_pkg.sv
src/ben_calc.sv
src/wdata_align.sv
src/wreq_stage.sv
src/store_queue.sv
src/fun_stq.sv
tests/fun_stq_assert.sv
tests/tb_fun_stq.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_fun_stq -f src.f

./obj_dir/Vtb_fun_stq > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Something failed" sim.log; then
  exit 1
fi
exit 0
